//--- verilog/anim_consts.svh
`ifndef ANIM_CONSTS_SVH
`define ANIM_CONSTS_SVH

// screen positions
`define DOG_START_X     10'd11
`define GROUND_Y        10'd290
`define HIDE_Y          10'd318

// walk geometry
`define WALK_BASE_X     10'd19
`define STEP_SIZE       10'd8
`define STRIDE          10'd32

// sniff after these walk loops
`define SNIFF_AT_1      4'd4
`define SNIFF_AT_2      4'd7
`define SNIFF_PAIRS     4'd3

// phase lengths in frames
`define SURPRISE_TICKS  4'd2
`define JUMP_TICKS      4'd10
`define WAIT_TICKS      4'd11

// duck launch
`define DUCK_Y          10'd300
`define DUCK_X_OFFSET   10'd64
`define DUCK_FRAME_BASE 5'd11

`define LFSR_SEED       16'hACE1

`endif

//--- verilog/duck_scene_pkg.sv
package duck_scene_pkg;

    // dog animation states in scene order
    typedef enum logic [4:0] {
        Rest,
        Walk1,
        Walk2,
        Walk3,
        Walk4,
        Sniff1,
        Sniff2,
        Surprised,
        JumpRise,
        JumpFall,
        WaitDuck,
        DuckStart1,
        DuckStart2,
        Hide
    } dogStateT;

    typedef enum logic [4:0] {
        FrameStand     = 5'd0,
        FrameWalkA     = 5'd1,
        FrameWalkB     = 5'd2,
        FrameWalkC     = 5'd3,
        FrameSniffA    = 5'd4,
        FrameSniffB    = 5'd5,
        FrameSurprised = 5'd6,
        FrameJumpUp    = 5'd7,
        FrameJumpDown  = 5'd8
    } dogFrameT;

    typedef enum logic [1:0] {DirNW, DirW, DirNE, DirE} duckDirT;

    typedef enum logic [1:0] {Black, Red, Green, Black2} duckColorT; // Black2 drawn black

    typedef logic [4:0] duckFrameT;

endpackage

//--- verilog/sceneRandom.sv
`timescale 1ns/1ps
`include "anim_consts.svh"

module sceneRandom (
    input  logic                      ANIM_Clk,
    input  logic                      Reset,
    output duck_scene_pkg::duckColorT randColor,
    output duck_scene_pkg::duckDirT   randDir,
    output logic [9:0]                randX
);

    logic [15:0] lfsr;
    logic [15:0] tapMask;

    // galois form, taps 16 14 13 11
    assign tapMask = lfsr[0] ? 16'hB400 : 16'h0000;

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            lfsr <= `LFSR_SEED;
        end
        else
        begin
            lfsr <= {1'b0, lfsr[15:1]} ^ tapMask; // one step per frame
        end
    end

    assign randColor = duck_scene_pkg::duckColorT'(lfsr[1:0]);
    assign randDir   = duck_scene_pkg::duckDirT'(lfsr[3:2]);

    // offset keeps the duck clear of the left edge
    assign randX = {1'b0, lfsr[12:4]} + `DUCK_X_OFFSET;

endmodule

//--- verilog/jumpPath.sv
`timescale 1ns/1ps
`include "anim_consts.svh"

module jumpPath (
    input  logic       jumpHalf,   // 0 rising, 1 falling
    input  logic [3:0] jumpIndex,
    output logic [9:0] jumpX,
    output logic [9:0] jumpY
);

    logic [9:0] arcY;
    logic [3:0] yIndex;

    // falling half walks the height table backwards
    assign yIndex = jumpHalf ? (4'd9 - ((jumpIndex > 4'd9) ? 4'd9 : jumpIndex)) : jumpIndex;

    always_comb
    begin
        case (yIndex)
            4'd0:    arcY = `GROUND_Y;
            4'd1:    arcY = 10'd274;
            4'd2:    arcY = 10'd260;
            4'd3:    arcY = 10'd248;
            4'd4:    arcY = 10'd238;
            4'd5:    arcY = 10'd229;
            4'd6:    arcY = 10'd222;
            4'd7:    arcY = 10'd217;
            4'd8:    arcY = 10'd213;
            default: arcY = 10'd212; // top of the leap
        endcase
    end

    always_comb
    begin
        jumpY = arcY;
        if (!jumpHalf)
        begin
            case (jumpIndex)
                4'd0:    jumpX = 10'd267;
                4'd1:    jumpX = 10'd276;
                4'd2:    jumpX = 10'd285;
                4'd3:    jumpX = 10'd294;
                4'd4:    jumpX = 10'd303;
                4'd5:    jumpX = 10'd312;
                4'd6:    jumpX = 10'd321;
                4'd7:    jumpX = 10'd330;
                4'd8:    jumpX = 10'd341;
                default: jumpX = 10'd352;
            endcase
        end
        else
        begin
            case (jumpIndex)
                4'd0:    jumpX = 10'd352;
                4'd1:    jumpX = 10'd363;
                4'd2:    jumpX = 10'd374;
                4'd3:    jumpX = 10'd383;
                4'd4:    jumpX = 10'd392;
                4'd5:    jumpX = 10'd401;
                4'd6:    jumpX = 10'd410;
                4'd7:    jumpX = 10'd419;
                4'd8:    jumpX = 10'd428;
                default: jumpX = 10'd437; // landing spot in the grass
            endcase
        end
    end

endmodule

//--- verilog/dogControl.sv
`timescale 1ns/1ps
`include "anim_consts.svh"

module dogControl (
    input  logic                     ANIM_Clk,
    input  logic                     Reset,
    input  logic                     Run,
    input  logic [9:0]               jumpX,
    input  logic [9:0]               jumpY,
    output logic                     jumpHalf,
    output logic [3:0]               jumpIndex,
    output logic [9:0]               dogX,
    output logic [9:0]               dogY,
    output duck_scene_pkg::dogFrameT dogFrame,
    output logic                     dogBehindGrass,
    output logic                     duckLaunch,
    output logic                     sceneRestart,
    output logic                     sceneDone
);

    duck_scene_pkg::dogStateT state;
    duck_scene_pkg::dogStateT nextState;
    logic [3:0] walkCount;     // finished walk loops
    logic [3:0] sniffCount;    // finished sniff pairs in this burst
    logic       secondBurst;
    logic [3:0] phaseCount;
    logic [3:0] phaseLimit;
    logic       timedState;
    logic       phaseEnd;
    logic       sniffStop;
    logic       burstDone;
    logic [9:0] walkX;
    logic [9:0] pauseX;

    always_comb
    begin
        timedState = 1'b1;
        phaseLimit = `WAIT_TICKS - 4'd1;
        case (state)
            duck_scene_pkg::Surprised: phaseLimit = `SURPRISE_TICKS - 4'd1;
            duck_scene_pkg::JumpRise,
            duck_scene_pkg::JumpFall:  phaseLimit = `JUMP_TICKS - 4'd1;
            duck_scene_pkg::WaitDuck:  phaseLimit = `WAIT_TICKS - 4'd1;
            default:                   timedState = 1'b0;
        endcase
    end

    assign phaseEnd  = timedState && (phaseCount == phaseLimit);
    assign sniffStop = (walkCount + 4'd1 == `SNIFF_AT_1) || (walkCount + 4'd1 == `SNIFF_AT_2);
    assign burstDone = (sniffCount == `SNIFF_PAIRS - 4'd1);

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state       <= duck_scene_pkg::Rest;
            walkCount   <= 4'd0;
            sniffCount  <= 4'd0;
            secondBurst <= 1'b0;
            phaseCount  <= 4'd0;
        end
        else
        begin
            state <= nextState;
            if (state == duck_scene_pkg::Rest)
            begin
                walkCount   <= 4'd0;
                sniffCount  <= 4'd0;
                secondBurst <= 1'b0;
            end
            if (state == duck_scene_pkg::Walk4)
                walkCount <= walkCount + 4'd1;
            if (state == duck_scene_pkg::Sniff2)
            begin
                if (burstDone)
                begin
                    sniffCount  <= 4'd0;
                    secondBurst <= 1'b1;
                end
                else
                begin
                    sniffCount <= sniffCount + 4'd1;
                end
            end
            // restarts at zero for each timed phase
            if (timedState && !phaseEnd)
                phaseCount <= phaseCount + 4'd1;
            else
                phaseCount <= 4'd0;
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            duck_scene_pkg::Rest:       if (Run) nextState = duck_scene_pkg::Walk1;
            duck_scene_pkg::Walk1:      nextState = duck_scene_pkg::Walk2;
            duck_scene_pkg::Walk2:      nextState = duck_scene_pkg::Walk3;
            duck_scene_pkg::Walk3:      nextState = duck_scene_pkg::Walk4;
            duck_scene_pkg::Walk4:
                nextState = sniffStop ? duck_scene_pkg::Sniff1 : duck_scene_pkg::Walk1;
            duck_scene_pkg::Sniff1:     nextState = duck_scene_pkg::Sniff2;
            duck_scene_pkg::Sniff2:
            begin
                if (!burstDone)
                    nextState = duck_scene_pkg::Sniff1;
                else if (secondBurst)
                    nextState = duck_scene_pkg::Surprised;
                else
                    nextState = duck_scene_pkg::Walk1; // first burst, keep walking
            end
            duck_scene_pkg::Surprised:  if (phaseEnd) nextState = duck_scene_pkg::JumpRise;
            duck_scene_pkg::JumpRise:   if (phaseEnd) nextState = duck_scene_pkg::JumpFall;
            duck_scene_pkg::JumpFall:   if (phaseEnd) nextState = duck_scene_pkg::WaitDuck;
            duck_scene_pkg::WaitDuck:   if (phaseEnd) nextState = duck_scene_pkg::DuckStart1;
            duck_scene_pkg::DuckStart1: nextState = duck_scene_pkg::DuckStart2;
            duck_scene_pkg::DuckStart2: nextState = duck_scene_pkg::Hide;
            default:                    nextState = duck_scene_pkg::Rest;
        endcase
    end

    assign walkX  = `WALK_BASE_X + `STRIDE * {6'd0, walkCount};
    // where the last Walk4 left the dog, walkCount has already moved on
    assign pauseX = walkX + 10'd3 * `STEP_SIZE - `STRIDE;

    assign jumpHalf  = (state >= duck_scene_pkg::JumpFall);
    assign jumpIndex = (state == duck_scene_pkg::JumpRise || state == duck_scene_pkg::JumpFall)
                       ? phaseCount : 4'hF;

    always_comb
    begin
        dogX     = pauseX;
        dogY     = `GROUND_Y;
        dogFrame = duck_scene_pkg::FrameStand;
        case (state)
            duck_scene_pkg::Rest:      dogX = `DOG_START_X;
            duck_scene_pkg::Walk1:
            begin
                dogX     = walkX;
                dogFrame = duck_scene_pkg::FrameWalkA;
            end
            duck_scene_pkg::Walk2:
            begin
                dogX     = walkX + `STEP_SIZE;
                dogFrame = duck_scene_pkg::FrameWalkB;
            end
            duck_scene_pkg::Walk3:
            begin
                dogX     = walkX + 10'd2 * `STEP_SIZE;
                dogFrame = duck_scene_pkg::FrameWalkC;
            end
            duck_scene_pkg::Walk4:
            begin
                dogX     = walkX + 10'd3 * `STEP_SIZE;
                dogFrame = duck_scene_pkg::FrameWalkC; // C held for two frames
            end
            duck_scene_pkg::Sniff1:    dogFrame = duck_scene_pkg::FrameSniffA;
            duck_scene_pkg::Sniff2:    dogFrame = duck_scene_pkg::FrameSniffB;
            duck_scene_pkg::Surprised: dogFrame = duck_scene_pkg::FrameSurprised;
            duck_scene_pkg::JumpRise:
            begin
                dogX     = jumpX;
                dogY     = jumpY;
                dogFrame = duck_scene_pkg::FrameJumpUp;
            end
            duck_scene_pkg::JumpFall:
            begin
                dogX     = jumpX;
                dogY     = jumpY;
                dogFrame = duck_scene_pkg::FrameJumpDown;
            end
            duck_scene_pkg::Hide:      dogY = `HIDE_Y;
            default:                   dogX = jumpX; // stays at the landing spot
        endcase
    end

    assign dogBehindGrass = (state == duck_scene_pkg::JumpFall);
    assign duckLaunch     = (state == duck_scene_pkg::DuckStart2);
    assign sceneRestart   = (state == duck_scene_pkg::Rest) || (state == duck_scene_pkg::Hide);
    assign sceneDone      = (state == duck_scene_pkg::Hide);

    stateLegal: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        !$isunknown(state) && (state inside {[duck_scene_pkg::Rest : duck_scene_pkg::Hide]}));

    // hide never repeats, so done is a single pulse
    donePulse: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        sceneDone |=> !sceneDone);

    launchOrder: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        duckLaunch |-> $past(state == duck_scene_pkg::DuckStart1));

endmodule

//--- verilog/duckLauncher.sv
`timescale 1ns/1ps
`include "anim_consts.svh"

module duckLauncher (
    input  logic                      ANIM_Clk,
    input  logic                      Reset,
    input  logic                      duckLaunch,
    input  logic                      sceneRestart,
    input  duck_scene_pkg::duckColorT randColor,
    input  duck_scene_pkg::duckDirT   randDir,
    input  logic [9:0]                randX,
    output logic [9:0]                duckX,
    output logic [9:0]                duckY,
    output duck_scene_pkg::duckFrameT duckFrame,
    output logic                      duckValid
);

    duck_scene_pkg::duckColorT color;
    duck_scene_pkg::duckDirT   dir;
    logic [1:0]                colorIndex;

    always_ff @(posedge ANIM_Clk)
    begin
        if (duckLaunch)
        begin
            color <= randColor;
            dir   <= randDir;
            duckX <= randX; // start column
        end
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
            duckValid <= 1'b0;
        else if (duckLaunch)
            duckValid <= 1'b1;
        else if (sceneRestart)
            duckValid <= 1'b0;
    end

    assign colorIndex = (color == duck_scene_pkg::Black2) ? 2'd0 : color;

    // four frames per direction, colour picks within the group
    assign duckFrame = `DUCK_FRAME_BASE + {1'b0, dir, 2'b00} + {3'b000, colorIndex};
    assign duckY     = `DUCK_Y;

    validFromLaunch: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        $rose(duckValid) |-> $past(duckLaunch));

endmodule

//--- verilog/introScene.sv
`timescale 1ns/1ps

module introScene (
    input  logic                      ANIM_Clk,
    input  logic                      Reset,
    input  logic                      Run,
    output logic [9:0]                dogX,
    output logic [9:0]                dogY,
    output duck_scene_pkg::dogFrameT  dogFrame,
    output logic                      dogBehindGrass,
    output logic [9:0]                duckX,
    output logic [9:0]                duckY,
    output duck_scene_pkg::duckFrameT duckFrame,
    output logic                      duckValid,
    output logic                      sceneDone
);

    duck_scene_pkg::duckColorT randColor;
    duck_scene_pkg::duckDirT   randDir;
    logic [9:0]                randX;
    logic                      jumpHalf;
    logic [3:0]                jumpIndex;
    logic [9:0]                jumpX;
    logic [9:0]                jumpY;
    logic                      duckLaunch;
    logic                      sceneRestart;

    sceneRandom rand0 (
        .ANIM_Clk  (ANIM_Clk),
        .Reset     (Reset),
        .randColor (randColor),
        .randDir   (randDir),
        .randX     (randX)
    );

    jumpPath path0 (
        .jumpHalf  (jumpHalf),
        .jumpIndex (jumpIndex),
        .jumpX     (jumpX),
        .jumpY     (jumpY)
    );

    dogControl dog0 (
        .ANIM_Clk       (ANIM_Clk),
        .Reset          (Reset),
        .Run            (Run),
        .jumpX          (jumpX),
        .jumpY          (jumpY),
        .jumpHalf       (jumpHalf),
        .jumpIndex      (jumpIndex),
        .dogX           (dogX),
        .dogY           (dogY),
        .dogFrame       (dogFrame),
        .dogBehindGrass (dogBehindGrass),
        .duckLaunch     (duckLaunch),
        .sceneRestart   (sceneRestart),
        .sceneDone      (sceneDone)
    );

    duckLauncher duck0 (
        .ANIM_Clk     (ANIM_Clk),
        .Reset        (Reset),
        .duckLaunch   (duckLaunch),
        .sceneRestart (sceneRestart),
        .randColor    (randColor),
        .randDir      (randDir),
        .randX        (randX),
        .duckX        (duckX),
        .duckY        (duckY),
        .duckFrame    (duckFrame),
        .duckValid    (duckValid)
    );

endmodule

//--- testbench/introScene_tb.sv
`timescale 1ns/1ps
`include "anim_consts.svh"

module introScene_tb;

    logic                      ANIM_Clk;
    logic                      Reset;
    logic                      Run;
    logic [9:0]                dogX;
    logic [9:0]                dogY;
    duck_scene_pkg::dogFrameT  dogFrame;
    logic                      dogBehindGrass;
    logic [9:0]                duckX;
    logic [9:0]                duckY;
    duck_scene_pkg::duckFrameT duckFrame;
    logic                      duckValid;
    logic                      sceneDone;

    // falling Y is the rising Y reversed
    int riseX [0:9] = '{267, 276, 285, 294, 303, 312, 321, 330, 341, 352};
    int fallX [0:9] = '{352, 363, 374, 383, 392, 401, 410, 419, 428, 437};
    int arcY  [0:9] = '{290, 274, 260, 248, 238, 229, 222, 217, 213, 212};

    // rows of idle ticks before Run, Run drop after start and scene count
    int idleTab  [0:3] = '{2, 0, 4, 1};
    bit dropTab  [0:3] = '{0, 1, 0, 1};
    int sceneTab [0:3] = '{1, 1, 2, 1};

    // reference model
    duck_scene_pkg::dogStateT  mState;
    duck_scene_pkg::duckFrameT mDuckFrame;
    logic [15:0]               mLfsr;
    logic [9:0]                mDuckX;
    logic [9:0]                pauseX;
    logic                      mValid;
    int walkLoops;
    int pairs;
    int bursts;
    int phase;
    int tickCount;

    int posErrors;
    int frameErrors;
    int flagErrors;
    int otherErrors;

    introScene dut0 (.*);

    always #50 ANIM_Clk = ~ANIM_Clk;

    task checkPos(input string name, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp)
        begin
            posErrors++;
            $display("error %s got %h expected %h at tick %0d", name, got, exp, tickCount);
        end
    endtask

    task checkDogFrame(input string name, input duck_scene_pkg::dogFrameT got,
                       input duck_scene_pkg::dogFrameT exp);
        if (got !== exp)
        begin
            frameErrors++;
            $display("error %s got %h expected %h at tick %0d", name, got, exp, tickCount);
        end
    endtask

    task checkDuckFrame(input string name, input duck_scene_pkg::duckFrameT got,
                        input duck_scene_pkg::duckFrameT exp);
        if (got !== exp)
        begin
            frameErrors++;
            $display("error %s got %h expected %h at tick %0d", name, got, exp, tickCount);
        end
    endtask

    task checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flagErrors++;
            $display("error %s got %h expected %h at tick %0d", name, got, exp, tickCount);
        end
    endtask

    task stepModel(input logic runIn);
        logic [15:0] old;
        int limit;
        old = mLfsr;
        tickCount++;
        limit = (mState == duck_scene_pkg::Surprised) ? `SURPRISE_TICKS :
                (mState == duck_scene_pkg::WaitDuck) ? `WAIT_TICKS : `JUMP_TICKS;
        if (mState == duck_scene_pkg::Rest || mState == duck_scene_pkg::Hide)
            mValid = 1'b0; // restart level
        case (mState)
            duck_scene_pkg::Rest:
            begin
                if (runIn)
                begin
                    mState    = duck_scene_pkg::Walk1;
                    walkLoops = 0;
                    bursts    = 0;
                end
            end
            duck_scene_pkg::Walk1: mState = duck_scene_pkg::Walk2;
            duck_scene_pkg::Walk2: mState = duck_scene_pkg::Walk3;
            duck_scene_pkg::Walk3: mState = duck_scene_pkg::Walk4;
            duck_scene_pkg::Walk4:
            begin
                pauseX = `WALK_BASE_X + 3 * `STEP_SIZE + `STRIDE * walkLoops;
                walkLoops++;
                pairs  = 0;
                mState = (walkLoops == `SNIFF_AT_1 || walkLoops == `SNIFF_AT_2)
                         ? duck_scene_pkg::Sniff1 : duck_scene_pkg::Walk1;
            end
            duck_scene_pkg::Sniff1: mState = duck_scene_pkg::Sniff2;
            duck_scene_pkg::Sniff2:
            begin
                pairs++;
                if (pairs < `SNIFF_PAIRS)
                    mState = duck_scene_pkg::Sniff1;
                else if (bursts == 0)
                begin
                    bursts = 1;
                    mState = duck_scene_pkg::Walk1;
                end
                else
                    mState = duck_scene_pkg::Surprised;
            end
            duck_scene_pkg::DuckStart1: mState = duck_scene_pkg::DuckStart2;
            duck_scene_pkg::DuckStart2:
            begin
                mValid     = 1'b1;
                mDuckX     = `DUCK_X_OFFSET + old[12:4];
                mDuckFrame = `DUCK_FRAME_BASE + 4 * old[3:2]
                             + ((old[1:0] == 2'd3) ? 0 : old[1:0]);
                mState     = duck_scene_pkg::Hide;
            end
            duck_scene_pkg::Hide: mState = duck_scene_pkg::Rest;
            default:
            begin
                // timed phases run in enum order
                phase++;
                if (phase == limit)
                begin
                    phase  = 0;
                    mState = duck_scene_pkg::dogStateT'(int'(mState) + 1);
                end
            end
        endcase
        // taps 16 14 13 11 land on bits 15 13 12 10 after the shift
        mLfsr = old >> 1;
        if (old[0])
            mLfsr = mLfsr ^ ((16'd1 << 15) | (16'd1 << 13) | (16'd1 << 12) | (16'd1 << 10));
    endtask

    task checkAll;
        logic [9:0] ex;
        logic [9:0] ey;
        duck_scene_pkg::dogFrameT ef;
        int n;
        ex = fallX[9]; // landing spot
        ey = `GROUND_Y;
        ef = duck_scene_pkg::FrameStand;
        n  = int'(mState) - int'(duck_scene_pkg::Walk1);
        case (mState)
            duck_scene_pkg::Rest: ex = `DOG_START_X;
            duck_scene_pkg::Walk1, duck_scene_pkg::Walk2,
            duck_scene_pkg::Walk3, duck_scene_pkg::Walk4:
            begin
                ex = `WALK_BASE_X + `STEP_SIZE * n + `STRIDE * walkLoops;
                ef = (n == 0) ? duck_scene_pkg::FrameWalkA :
                     (n == 1) ? duck_scene_pkg::FrameWalkB : duck_scene_pkg::FrameWalkC;
            end
            duck_scene_pkg::Sniff1:
            begin
                ex = pauseX;
                ef = duck_scene_pkg::FrameSniffA;
            end
            duck_scene_pkg::Sniff2:
            begin
                ex = pauseX;
                ef = duck_scene_pkg::FrameSniffB;
            end
            duck_scene_pkg::Surprised:
            begin
                ex = pauseX;
                ef = duck_scene_pkg::FrameSurprised;
            end
            duck_scene_pkg::JumpRise:
            begin
                ex = riseX[phase];
                ey = arcY[phase];
                ef = duck_scene_pkg::FrameJumpUp;
            end
            duck_scene_pkg::JumpFall:
            begin
                ex = fallX[phase];
                ey = arcY[9 - phase];
                ef = duck_scene_pkg::FrameJumpDown;
            end
            duck_scene_pkg::Hide:
            begin
                ex = pauseX;
                ey = `HIDE_Y;
            end
            default: ;
        endcase
        checkPos("dogX", dogX, ex);
        checkPos("dogY", dogY, ey);
        checkDogFrame("dogFrame", dogFrame, ef);
        checkFlag("dogBehindGrass", dogBehindGrass, mState == duck_scene_pkg::JumpFall);
        checkFlag("sceneDone", sceneDone, mState == duck_scene_pkg::Hide);
        checkFlag("duckValid", duckValid, mValid);
        if (mValid)
        begin
            checkPos("duckX", duckX, mDuckX);
            checkPos("duckY", duckY, `DUCK_Y);
            checkDuckFrame("duckFrame", duckFrame, mDuckFrame);
        end
    endtask

    // step the model with the Run the DUT samples and check at mid cycle
    task tick(input logic runNext);
        @(posedge ANIM_Clk);
        stepModel(Run);
        Run <= runNext;
        @(negedge ANIM_Clk);
        checkAll();
    endtask

    initial
    begin
        int extra;
        int waitTicks;
        ANIM_Clk  = 1'b0;
        Reset     = 1'b1;
        Run       = 1'b0;
        void'($urandom(25));
        mState    = duck_scene_pkg::Rest;
        mLfsr     = `LFSR_SEED;
        mValid    = 1'b0;
        pauseX    = '0;
        walkLoops = 0;
        pairs     = 0;
        bursts    = 0;
        phase     = 0;
        tickCount = 0;
        posErrors = 0;
        frameErrors = 0;
        flagErrors  = 0;
        otherErrors = 0;
        repeat (2) @(posedge ANIM_Clk);
        Reset <= 1'b0;
        @(negedge ANIM_Clk);
        checkAll();
        for (int row = 0; row < 4; row++)
        begin
            for (int sc = 0; sc < sceneTab[row]; sc++)
            begin
                extra = $urandom % 4;
                repeat (idleTab[row] + extra) tick(1'b0);
                tick(1'b1);
                waitTicks = 0;
                while (!sceneDone && waitTicks < 200)
                begin
                    tick(!dropTab[row]); // drop rows release Run right after the start
                    waitTicks++;
                end
                if (!sceneDone)
                begin
                    otherErrors++;
                    $display("timeout: no sceneDone within 200 ticks in row %0d", row);
                end
            end
        end
        repeat (3) tick(1'b0);
        $display("errors: position %0d, frame %0d, flag %0d, other %0d",
                 posErrors, frameErrors, flagErrors, otherErrors);
        if (posErrors + frameErrors + flagErrors + otherErrors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/duck_scene_pkg.sv
verilog/sceneRandom.sv
verilog/jumpPath.sv
verilog/dogControl.sv
verilog/duckLauncher.sv
verilog/introScene.sv
testbench/introScene_tb.sv

//--- Bender.yml
package:
  name: duck_scene

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/duck_scene_pkg.sv
      - verilog/sceneRandom.sv
      - verilog/jumpPath.sv
      - verilog/dogControl.sv
      - verilog/duckLauncher.sv
      - verilog/introScene.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/introScene_tb.sv
